// File: verilog.f
+incdir+include
source/obj_pkg.sv
source/obj_scan.sv
source/obj_draw.sv
source/obj_linebuf.sv
source/obj_top.sv
tb/obj_clk.sv
tb/obj_tb.sv

// File: run.sh
#!/bin/sh
# Build the sprite layer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module obj_tb -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vobj_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

// File: tb/obj_tb.sv
// Sprite layer testbench, ROM answers each request after 0 to 3 wait cycles
// Each table row is drawn on one line, then read twice on the next

`default_nettype none

`include "obj_defs.svh"

module obj_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import obj_pkg::*;

    localparam int CLK_NS      = 100;
    localparam int NROW        = 7;
    localparam int NSLOT       = 4;
    localparam int LB_SIZE     = 2**`OBJ_LB_AW;
    localparam int ROW_CYC     = 3 * (LB_SIZE + 8) + 40;   // Table load plus two lines
    localparam int WATCH_NS    = (LB_SIZE + 100 + NROW * ROW_CYC) * 2 * CLK_NS;
    localparam int NO_CHECK    = 0;
    localparam int CHECK_EXP   = 1;
    localparam int CHECK_CLEAR = 2;

    // One sprite entry as the host sees it
    typedef struct packed {
        logic [7:0]  top;
        logic [7:0]  bot;
        logic [8:0]  xpos;
        logic [2:0]  bank;
        logic        flip;
        logic [14:0] offs;
        logic [7:0]  pitch;
        logic [1:0]  prio;
        logic [5:0]  pal;
    } spr_t;

    logic                    clk;
    logic                    rst;
    logic                    hstart;
    logic [7:0]              vrender;
    logic [`OBJ_LB_AW-1:0]   hdump;
    logic                    tab_we;
    logic [`OBJ_TAB_AW-1:0]  tab_addr;
    logic [15:0]             tab_din;
    logic                    obj_cs;
    logic [`OBJ_ROM_AW-1:0]  obj_addr;
    logic                    obj_ok = 1'b0;
    logic [15:0]             obj_data = 16'h0000;
    obj_pkg::obj_pxl_t       pxl;

    logic [15:0]             rom [2**`OBJ_ROM_AW];
    spr_t                    sprs [NROW][NSLOT];
    int                      nspr [NROW];      // Entries before the end marker
    int                      nhid [NROW];      // Entries after it
    logic [7:0]              row_vr [NROW];
    logic [11:0]             exp_line [LB_SIZE];
    int                      n_checks;
    int                      n_errors;
    int unsigned             ack_wait = 0;     // First request answered at once

    obj_clk #(.PERIOD_NS(CLK_NS), .RST_CYC(3)) u_clk (.clk(clk), .rst(rst));

    obj_top UUT (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .vrender  (vrender),
        .hdump    (hdump),
        .tab_we   (tab_we),
        .tab_addr (tab_addr),
        .tab_din  (tab_din),
        .obj_cs   (obj_cs),
        .obj_addr (obj_addr),
        .obj_ok   (obj_ok),
        .obj_data (obj_data),
        .pxl      (pxl)
    );

    // Hash of the whole address, with forced end and hole nibbles
    function automatic logic [15:0] rom_word(input logic [`OBJ_ROM_AW-1:0] a);
        logic [31:0] h;
        logic [15:0] w;
        h = 32'(a) * 32'h9E37_79B1;
        h = h ^ (h >> 13);
        w = h[31:16] ^ h[15:0];
        if (a[2:0] == 3'd7)
            w[3:0] = 4'hF;      // Last nibble going up
        if (a[2:0] == 3'd0)
            w[15:12] = 4'hF;    // Last nibble going down
        if (a[2:0] == 3'd3)
            w[11:8] = 4'hF;     // Hole mid word
        return w;
    endfunction

    // ROM with random wait, ok held one cycle
    initial begin
        void'($urandom(15));
        forever begin
            @(posedge clk);
            if (obj_cs && !obj_ok) begin
                if (ack_wait == 0) begin
                    obj_ok   <= 1'b1;
                    obj_data <= rom[obj_addr];
                    ack_wait <= $urandom % 4;   // Delay for the next request
                end else begin
                    ack_wait <= ack_wait - 1;
                end
            end else begin
                obj_ok <= 1'b0;
            end
        end
    end

    task automatic put_sprite(input int r, input int i, input int top, input int bot,
                              input int xpos, input int bank, input int flip,
                              input int offs, input int pitch, input int prio,
                              input int pal);
        spr_t s;
        s.top   = 8'(top);
        s.bot   = 8'(bot);
        s.xpos  = 9'(xpos);
        s.bank  = 3'(bank);
        s.flip  = 1'(flip);
        s.offs  = 15'(offs);
        s.pitch = 8'(pitch);
        s.prio  = 2'(prio);
        s.pal   = 6'(pal);
        sprs[r][i] = s;
    endtask

    // Stimulus table, one row per tested line
    task automatic fill_rows();
        // Plain sprite, row 10 of a pitch 8 sprite
        row_vr[0] = 8'd20;
        nspr[0] = 1;
        nhid[0] = 0;
        put_sprite(0, 0, 10, 40, 16, 0, 0, 'h0100, 8, 1, 'h05);
        // Flipped, walks down
        row_vr[1] = 8'd50;
        nspr[1] = 1;
        nhid[1] = 0;
        put_sprite(1, 0, 50, 60, 200, 3, 1, 'h0427, 4, 2, 'h2A);
        // Two off the line, two overlapping
        row_vr[2] = 8'd100;
        nspr[2] = 4;
        nhid[2] = 0;
        put_sprite(2, 0, 90, 110, 300, 5, 0, 'h1234, 16, 0, 'h11);
        put_sprite(2, 1, 101, 120, 40, 1, 0, 'h0200, 2, 1, 'h22);   // Starts below
        put_sprite(2, 2, 80, 100, 60, 2, 0, 'h0300, 2, 2, 'h33);    // Ends above
        put_sprite(2, 3, 95, 105, 310, 2, 1, 'h2345, 3, 3, 'h3F);
        // Wraps past the right edge
        row_vr[3] = 8'd7;
        nspr[3] = 1;
        nhid[3] = 0;
        put_sprite(3, 0, 0, 16, 510, 7, 0, 'h7003, 2, 1, 'h09);
        // Visible entry behind the end marker
        row_vr[4] = 8'd33;
        nspr[4] = 1;
        nhid[4] = 1;
        put_sprite(4, 0, 30, 34, 100, 4, 1, 'h0555, 5, 2, 'h15);
        put_sprite(4, 1, 0, 255, 120, 6, 0, 'h0AAA, 1, 3, 'h33);
        // Large pitch
        row_vr[5] = 8'd200;
        nspr[5] = 2;
        nhid[5] = 0;
        put_sprite(5, 0, 150, 250, 0, 6, 0, 'h0010, 'h40, 0, 'h20);
        put_sprite(5, 1, 199, 201, 8, 1, 1, 'h3FF0, 'h80, 3, 'h01);
        // Row 0 again under other wait states
        row_vr[6] = row_vr[0];
        nspr[6] = nspr[0];
        nhid[6] = nhid[0];
        sprs[6][0] = sprs[0][0];
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    // Host writes, then the end marker, then any hidden entries
    task automatic write_entries(input int r);
        spr_t s;
        int   n;
        n = nspr[r] + 1 + nhid[r];
        for (int e = 0; e < n; e++) begin
            s = sprs[r][(e < nspr[r]) ? e : e - 1];
            for (int w = 0; w < 4; w++) begin
                @(posedge clk);
                tab_we   <= 1'b1;
                tab_addr <= `OBJ_TAB_AW'(e * 4 + w);
                if (e == nspr[r])
                    tab_din <= (w == 0) ? 16'h00FF : 16'h0000;  // Top of 0xFF
                else begin
                    case (w)
                        0:       tab_din <= {s.bot, s.top};
                        1:       tab_din <= {2'b00, s.prio, s.bank, s.xpos};
                        2:       tab_din <= {s.pitch, 2'b00, s.pal};
                        default: tab_din <= {s.flip, s.offs};
                    endcase
                end
            end
        end
        @(posedge clk);
        tab_we  <= 1'b0;
        vrender <= row_vr[r];
    endtask

    // Expected line from the sprite rules, later entries on top
    task automatic predict_line(input int r);
        spr_t                    s;
        logic [7:0]              vr;
        logic [7:0]              rowoff;
        logic [15:0]             raw;
        logic [15:0]             w;
        logic [3:0]              nib;
        logic [8:0]              x;
        logic [`OBJ_ROM_AW-1:0]  ra;
        logic                    done;
        int                      guard;
        vr = row_vr[r];
        for (int p = 0; p < LB_SIZE; p++)
            exp_line[p] = `OBJ_CLR;
        for (int i = 0; i < nspr[r]; i++) begin
            s = sprs[r][i];
            if (s.top <= vr && vr < s.bot) begin
                rowoff = vr - s.top;
                raw    = {s.flip, s.offs} + 16'(s.pitch) * 16'(rowoff);
                x      = s.xpos;
                done   = 1'b0;
                guard  = 0;
                while (!done && guard < 64) begin
                    ra = {s.bank[1:0], s.bank[2], raw[14:0]};
                    w  = rom[ra];
                    for (int n = 0; n < 4; n++) begin
                        nib = raw[15] ? w[n * 4 +: 4] : w[(3 - n) * 4 +: 4];
                        if (nib != 4'hF)
                            exp_line[x] = {s.prio, s.pal, nib};
                        else if (n == 3)
                            done = 1'b1;    // End nibble
                        x = x + 9'd1;
                    end
                    if (!done)
                        raw = raw[15] ? raw - 16'd1 : raw + 16'd1;
                    guard++;
                end
            end
        end
    endtask

    // New line, hstart drops again on the first hdump edge
    task automatic start_line();
        @(posedge clk);
        hstart <= 1'b1;
    endtask

    // hdump sweep, pxl for address j-1 settles after edge j
    task automatic sweep_line(input int mode, input int r);
        for (int j = 0; j <= LB_SIZE; j++) begin
            @(posedge clk);
            hstart <= 1'b0;
            if (j < LB_SIZE)
                hdump <= `OBJ_LB_AW'(j);
            @(negedge clk);
            if (j > 0 && mode == CHECK_EXP)
                check_value($sformatf("pxl[%0d] (row %0d)", j - 1, r), 32'(pxl),
                            32'(exp_line[j - 1]));
            else if (j > 0 && mode == CHECK_CLEAR)
                check_value($sformatf("pxl[%0d] (row %0d)", j - 1, r), 32'(pxl),
                            32'(`OBJ_CLR));
        end
    endtask

    initial begin
        hstart   = 1'b0;
        vrender  = 8'd0;
        hdump    = '0;
        tab_we   = 1'b0;
        tab_addr = '0;
        tab_din  = 16'h0000;
        n_checks = 0;
        n_errors = 0;
        for (int a = 0; a < 2**`OBJ_ROM_AW; a++)
            rom[a] = rom_word(`OBJ_ROM_AW'(a));
        fill_rows();
        wait (rst === 1'b0);
        repeat (LB_SIZE + 8) @(posedge clk);   // Reset clear sweep
        for (int r = 0; r < NROW; r++) begin
            write_entries(r);
            predict_line(r);
            // Drawing line, display half untouched only after reset
            start_line();
            sweep_line((r == 0) ? CHECK_CLEAR : NO_CHECK, r);
            if (UUT.busy !== 1'b0) begin
                n_errors++;
                $display("Row %0d sprite draw was still running at the end of its line", r);
            end
            // Display line, then the same half again after clearing
            start_line();
            sweep_line(CHECK_EXP, r);
            sweep_line(CHECK_CLEAR, r);
        end
        $display("Checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // Watchdog sized from the row count
    initial begin
        #(WATCH_NS);
        $display("Timeout, the run did not finish within %0d ns", WATCH_NS);
        $display("Checks %0d, errors %0d", n_checks, n_errors);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/obj_clk.sv
// Testbench clock and reset, reset released on a rising edge
// Reset is held for RST_CYC rising edges from time zero

`default_nettype none

module obj_clk #(
    parameter int PERIOD_NS = 100,
    parameter int RST_CYC   = 3
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #(PERIOD_NS / 2) clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;    // Released after the last reset edge
    end

endmodule

`default_nettype wire

// File: source/obj_top.sv
// Sprite layer top, host writes the attribute table at any time
// Video timing comes from outside, hstart once per line before the hdump sweep

`default_nettype none

`include "obj_defs.svh"

module obj_top (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    hstart,
    input  wire logic [7:0]              vrender,
    input  wire logic [`OBJ_LB_AW-1:0]   hdump,
    input  wire logic                    tab_we,
    input  wire logic [`OBJ_TAB_AW-1:0]  tab_addr,
    input  wire logic [15:0]             tab_din,
    output logic                         obj_cs,
    output logic [`OBJ_ROM_AW-1:0]       obj_addr,
    input  wire logic                    obj_ok,
    input  wire logic [15:0]             obj_data,
    output obj_pkg::obj_pxl_t            pxl
);
    import obj_pkg::*;

    logic [15:0]             tab_ram [2**`OBJ_TAB_AW];
    logic [`OBJ_TAB_AW-1:0]  scan_addr;
    logic [15:0]             tab_dout;

    // Scan to draw
    logic                    start;
    logic                    busy;
    logic [`OBJ_LB_AW-1:0]   xpos;
    obj_offset_u             offset;
    logic [2:0]              bank;
    logic [1:0]              prio;
    logic [5:0]              pal;

    // Draw to buffer
    obj_pxl_t                bf_data;
    logic                    bf_we;
    logic [`OBJ_LB_AW-1:0]   bf_addr;

    // Attribute RAM, host write and registered scan read
    always_ff @(posedge clk) begin
        if (tab_we)
            tab_ram[tab_addr] <= tab_din;
        tab_dout <= tab_ram[scan_addr];
    end

    obj_scan u_scan (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .vrender  (vrender),
        .tab_addr (scan_addr),
        .tab_dout (tab_dout),
        .busy     (busy),
        .start    (start),
        .xpos     (xpos),
        .offset   (offset),
        .bank     (bank),
        .prio     (prio),
        .pal      (pal)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .start    (start),
        .busy     (busy),
        .xpos     (xpos),
        .offset   (offset),
        .bank     (bank),
        .prio     (prio),
        .pal      (pal),
        .obj_ok   (obj_ok),
        .obj_cs   (obj_cs),
        .obj_addr (obj_addr),
        .obj_data (obj_data),
        .bf_data  (bf_data),
        .bf_we    (bf_we),
        .bf_addr  (bf_addr)
    );

    obj_linebuf u_linebuf (
        .clk      (clk),
        .rst      (rst),
        .hstart   (hstart),
        .bf_we    (bf_we),
        .bf_addr  (bf_addr),
        .bf_data  (bf_data),
        .hdump    (hdump),
        .pxl      (pxl)
    );

endmodule

`default_nettype wire

// File: source/obj_linebuf.sv
// Double line buffer, hdump must sweep every location each line to clear it
// Writes are lost during the 512-cycle clear sweep after reset

`default_nettype none

`include "obj_defs.svh"

module obj_linebuf (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   hstart,
    input  wire logic                   bf_we,
    input  wire logic [`OBJ_LB_AW-1:0]  bf_addr,
    input  wire obj_pkg::obj_pxl_t      bf_data,
    input  wire logic [`OBJ_LB_AW-1:0]  hdump,
    output obj_pkg::obj_pxl_t           pxl
);
    import obj_pkg::*;

    localparam int DEPTH = 2**`OBJ_LB_AW;

    obj_pxl_t               mem [2][DEPTH];
    logic                   half;           // Half being drawn
    logic                   sweep_on;
    logic [`OBJ_LB_AW-1:0]  sweep_cnt;
    logic                   clr_half;       // Half read last cycle
    logic [`OBJ_LB_AW-1:0]  clr_addr;
    logic [1:0]             we;
    logic [`OBJ_LB_AW-1:0]  wa [2];
    obj_pxl_t               wd [2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half      <= 1'b0;
            sweep_on  <= 1'b1;
            sweep_cnt <= '0;
        end else begin
            if (hstart)
                half <= ~half;
            if (sweep_on) begin
                sweep_cnt <= sweep_cnt + 1'b1;
                if (&sweep_cnt)
                    sweep_on <= 1'b0;
            end
        end
    end

    // One write port per half
    // Sweep first, then the read-back clear, then sprite pixels
    always_comb begin
        for (int h = 0; h < 2; h++) begin
            if (sweep_on) begin
                we[h] = 1'b1;
                wa[h] = sweep_cnt;
                wd[h] = `OBJ_CLR;
            end else if (clr_half == 1'(h)) begin
                we[h] = 1'b1;
                wa[h] = clr_addr;
                wd[h] = `OBJ_CLR;
            end else begin
                we[h] = bf_we && half == 1'(h);
                wa[h] = bf_addr;
                wd[h] = bf_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int h = 0; h < 2; h++) begin
            if (we[h])
                mem[h][wa[h]] <= wd[h];
        end
        pxl      <= mem[~half][hdump];  // Line drawn last time round
        clr_half <= ~half;
        clr_addr <= hdump;              // Cleared on the next cycle
    end

endmodule

`default_nettype wire

// File: source/obj_draw.sv
// Sprite line drawer, a ROM fetch waits on obj_ok for any number of cycles
// Nibble 0xF is transparent, 0xF as the fourth nibble drawn ends the sprite

`default_nettype none

`include "obj_defs.svh"

module obj_draw (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   hstart,
    input  wire logic                   start,
    output logic                        busy,
    input  wire logic [`OBJ_LB_AW-1:0]  xpos,
    input  wire obj_pkg::obj_offset_u   offset,
    input  wire logic [2:0]             bank,
    input  wire logic [1:0]             prio,
    input  wire logic [5:0]             pal,
    input  wire logic                   obj_ok,
    output logic                        obj_cs,
    output logic [`OBJ_ROM_AW-1:0]      obj_addr,
    input  wire logic [15:0]            obj_data,
    output obj_pkg::obj_pxl_t           bf_data,
    output logic                        bf_we,
    output logic [`OBJ_LB_AW-1:0]       bf_addr
);
    import obj_pkg::*;

    obj_offset_u            cur;        // Word being fetched or drawn
    logic [15:0]            word;       // Shifts one nibble per draw cycle
    logic [1:0]             cnt;
    logic                   draw;
    logic [`OBJ_LB_AW-1:0]  pos;        // Next buffer location
    logic [2:0]             bank_r;
    logic [1:0]             prio_r;
    logic [5:0]             pal_r;
    logic [3:0]             nib;
    logic                   take;
    logic                   last;

    assign nib      = cur.f.hflip ? word[3:0] : word[15:12];
    assign take     = obj_cs && obj_ok;
    assign last     = draw && cnt == 2'd3;
    assign obj_addr = {bank_r[1:0], bank_r[2], cur.f.addr};   // ROM bank wiring

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            obj_cs <= 1'b0;
            draw   <= 1'b0;
            cnt    <= '0;
            bf_we  <= 1'b0;
        end else if (hstart) begin
            busy   <= 1'b0;     // Abort, the line is over
            obj_cs <= 1'b0;
            draw   <= 1'b0;
            bf_we  <= 1'b0;
        end else if (start) begin
            busy   <= 1'b1;
            obj_cs <= 1'b1;     // First word request
            draw   <= 1'b0;
            bf_we  <= 1'b0;
        end else begin
            bf_we <= draw && nib != 4'hF;   // Skip transparent
            if (take) begin
                obj_cs <= 1'b0;
                draw   <= 1'b1;
                cnt    <= '0;
            end
            if (draw) begin
                cnt <= cnt + 1'b1;
                if (last) begin
                    draw <= 1'b0;
                    if (nib == 4'hF)
                        busy <= 1'b0;   // Terminating word done
                    else
                        obj_cs <= 1'b1; // Go for the next word
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur    <= offset;
            pos    <= xpos;
            bank_r <= bank;
            prio_r <= prio;
            pal_r  <= pal;
        end else begin
            if (take)
                word <= obj_data;
            if (draw) begin
                word           <= cur.f.hflip ? word >> 4 : word << 4;
                pos            <= pos + 1'b1;
                bf_addr        <= pos;
                bf_data.prio   <= prio_r;
                bf_data.pal    <= pal_r;
                bf_data.colour <= nib;
                // Carry out of addr may toggle hflip
                if (last && nib != 4'hF)
                    cur.raw <= cur.raw + (cur.f.hflip ? 16'hFFFF : 16'h0001);
            end
        end
    end

    // ROM request held steady until acknowledged
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        obj_cs && !obj_ok && !hstart |=> $stable(obj_addr));

endmodule

`default_nettype wire

// File: source/obj_scan.sv
// Attribute table walker, restarts at entry 0 on every hstart
// A top line of 0xFF ends the list, hidden entries cost no draw time

`default_nettype none

`include "obj_defs.svh"

module obj_scan (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   hstart,
    input  wire logic [7:0]             vrender,
    output logic [`OBJ_TAB_AW-1:0]      tab_addr,
    input  wire logic [15:0]            tab_dout,
    input  wire logic                   busy,
    output logic                        start,
    output logic [8:0]                  xpos,
    output obj_pkg::obj_offset_u        offset,
    output logic [2:0]                  bank,
    output logic [1:0]                  prio,
    output logic [5:0]                  pal
);
    import obj_pkg::*;

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_ADDR = 3'd1;   // Word 0 address on the RAM
    localparam logic [2:0] S_W0   = 3'd2;
    localparam logic [2:0] S_W1   = 3'd3;
    localparam logic [2:0] S_W2   = 3'd4;
    localparam logic [2:0] S_W3   = 3'd5;
    localparam logic [2:0] S_WAIT = 3'd6;   // Visible sprite waiting for the drawer

    logic [2:0]             st;
    logic [`OBJ_TAB_AW-3:0] idx;            // Entry number
    logic [1:0]             sub;            // Word within the entry
    logic [7:0]             ytop, ybot;
    logic [7:0]             pitch;
    logic [7:0]             row;
    logic                   vis;
    logic                   adv;
    obj_offset_u            line_offs;

    assign tab_addr = {idx, sub};

    // Row inside the sprite, only meaningful when vis
    assign row = vrender - ytop;
    assign vis = (ytop <= vrender) && (vrender < ybot);

    // Word 3 is on tab_dout during S_W3
    always_comb begin
        line_offs.raw = tab_dout + {8'd0, pitch} * {8'd0, row};
    end

    // Move to the next entry
    assign adv = (st == S_W3 && !vis) || (st == S_WAIT && !busy);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st    <= S_IDLE;
            idx   <= '0;
            sub   <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (hstart) begin
                st  <= S_ADDR;  // New line, back to entry 0
                idx <= '0;
                sub <= '0;
            end else if (adv) begin
                if (st == S_WAIT)
                    start <= 1'b1;  // Drawer idle, hand the sprite over
                if (&idx) begin
                    st <= S_IDLE;   // Table exhausted
                end else begin
                    idx <= idx + 1'b1;
                    sub <= '0;
                    st  <= S_ADDR;
                end
            end else begin
                case (st)
                    S_ADDR: begin
                        sub <= 2'd1;
                        st  <= S_W0;
                    end
                    S_W0: begin
                        if (tab_dout[7:0] == 8'hFF) begin
                            st <= S_IDLE;   // End marker hides the rest
                        end else begin
                            sub <= 2'd2;
                            st  <= S_W1;
                        end
                    end
                    S_W1: begin
                        sub <= 2'd3;
                        st  <= S_W2;
                    end
                    S_W2:    st <= S_W3;
                    S_W3:    st <= S_WAIT;  // Only reached when visible
                    default: ;
                endcase
            end
        end
    end

    // Entry fields, captured as each word comes out of the RAM
    always_ff @(posedge clk) begin
        case (st)
            S_W0: begin
                ytop <= tab_dout[7:0];
                ybot <= tab_dout[15:8];
            end
            S_W1: begin
                xpos <= tab_dout[8:0];
                bank <= tab_dout[11:9];
                prio <= tab_dout[13:12];
            end
            S_W2: begin
                pal   <= tab_dout[5:0];
                pitch <= tab_dout[15:8];
            end
            S_W3:    offset <= line_offs;   // Start word for this line
            default: ;
        endcase
    end

    // Drawer must be idle when a sprite is handed over
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

endmodule

`default_nettype wire

// File: source/obj_pkg.sv
// Types shared by the sprite layer
// The offset word steps as a counter, so a carry out of addr can flip hflip

`default_nettype none

package obj_pkg;

    // Draw offset word, word 3 of an attribute entry
    typedef union packed {
        logic [15:0] raw;          // Counter view
        struct packed {
            logic        hflip;    // Reverses nibble order and walk direction
            logic [14:0] addr;     // ROM word inside the bank
        } f;
    } obj_offset_u;

    // One line buffer location
    typedef struct packed {
        logic [1:0] prio;          // Layer priority tag
        logic [5:0] pal;           // Palette select
        logic [3:0] colour;        // 0xF means nothing drawn
    } obj_pxl_t;

endpackage

`default_nettype wire

// File: include/obj_defs.svh
// Sizes shared by the sprite layer blocks
// Table entries are 4 words each and the ROM word address carries 3 bank bits

`ifndef OBJ_DEFS_SVH
`define OBJ_DEFS_SVH

// Attribute RAM, 128 entries of 4 words
`define OBJ_TAB_AW 9

// Line buffer, one pixel per address
`define OBJ_LB_AW 9

// Graphics ROM word address
`define OBJ_ROM_AW 18

// Empty pixel value, also the transparent colour code
`define OBJ_CLR 12'hFFF

`endif
